// ==== core_defines.svh ====
/*
 * core hazard subsystem defines
 * register-address width and stage-register mask layout
 */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// architectural register number, x0 to x31
`define REG_ADDR_W 5

// ---------------------------------------------------------------------------
// stage-register mask layout
// one bit per pipeline register, used by both enable and kill masks
// ---------------------------------------------------------------------------
`define REG_IF_DEC  0
`define REG_DEC_EXE 1
`define REG_EXE_MEM 2
`define REG_MEM_WB  3

// number of pipeline registers between the five stages
`define STAGE_REGS 4

`endif

// ==== core_pkg.sv ====
/*
 * core package
 * types shared by the hazard tracker, forwarding, stall and combiner logic
 */
`include "core_defines.svh"

package core_pkg;

	// architectural register number, x0 never causes a hazard
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// hazard class of a decoded instruction
	typedef enum logic [1:0] {
		HZRD_NONE  = 2'b00,
		HZRD_JUMP  = 2'b01,
		HZRD_BRNCH = 2'b10,
		HZRD_LOAD  = 2'b11
	} hzrd_cmd_t;

	// execute bypass mask
	// bit 0 mem to src1, bit 1 mem to src2
	// bit 2 wb to src1, bit 3 wb to src2
	typedef logic [3:0] bp_sel_t;

	// one bit per stage register, indexed by the REG_ macros
	typedef logic [`STAGE_REGS-1:0] stage_mask_t;

endpackage

// ==== core_stage_track.sv ====
/*
 * core stage tracker
 * carries the hazard fields of each instruction from decode to write-back
 * under the same enable and kill masks as the core pipeline registers
 */
`include "core_defines.svh"

module core_stage_track (
	input  logic                  clk,
	input  logic                  rst_n,
	input  core_pkg::reg_addr_t   dec_rs1,
	input  core_pkg::reg_addr_t   dec_rs2,
	input  core_pkg::reg_addr_t   dec_rd,
	input  logic                  dec_we,
	input  core_pkg::hzrd_cmd_t   dec_cmd,
	input  core_pkg::stage_mask_t enb_bus,
	input  core_pkg::stage_mask_t kill_bus,
	input  logic                  nop_gen,
	output core_pkg::reg_addr_t   exe_rs1,
	output core_pkg::reg_addr_t   exe_rs2,
	output core_pkg::reg_addr_t   exe_rd,
	output core_pkg::reg_addr_t   mem_rs2,
	output core_pkg::reg_addr_t   mem_rd,
	output core_pkg::reg_addr_t   wb_rd,
	output logic                  exe_we,
	output logic                  mem_we,
	output logic                  wb_we,
	output core_pkg::hzrd_cmd_t   exe_cmd
);
	import core_pkg::*;

	// decode/execute takes a bubble on kill or on nop insertion
	logic dec_exe_flush;

	assign dec_exe_flush = kill_bus[`REG_DEC_EXE] | nop_gen;

	// -----------------------------------------------------------------------
	// decode to execute
	// -----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n || (enb_bus[`REG_DEC_EXE] && dec_exe_flush)) begin
			exe_rs1 <= '0;
			exe_rs2 <= '0;
			exe_rd  <= '0;
			exe_we  <= 1'b0;
			exe_cmd <= HZRD_NONE;
		end else if (enb_bus[`REG_DEC_EXE]) begin
			exe_rs1 <= dec_rs1;
			exe_rs2 <= dec_rs2;
			exe_rd  <= dec_rd;
			exe_we  <= dec_we;
			exe_cmd <= dec_cmd;
		end
	end

	// execute to memory, only store data source and destination matter
	always_ff @(posedge clk) begin
		if (!rst_n || (enb_bus[`REG_EXE_MEM] && kill_bus[`REG_EXE_MEM])) begin
			mem_rs2 <= '0;
			mem_rd  <= '0;
			mem_we  <= 1'b0;
		end else if (enb_bus[`REG_EXE_MEM]) begin
			mem_rs2 <= exe_rs2;
			mem_rd  <= exe_rd;
			mem_we  <= exe_we;
		end
	end

	// memory to write-back
	always_ff @(posedge clk) begin
		if (!rst_n || (enb_bus[`REG_MEM_WB] && kill_bus[`REG_MEM_WB])) begin
			wb_rd <= '0;
			wb_we <= 1'b0;
		end else if (enb_bus[`REG_MEM_WB]) begin
			wb_rd <= mem_rd;
			wb_we <= mem_we;
		end
	end

endmodule

// ==== core_fwd_unit.sv ====
/*
 * core forwarding unit
 * picks the bypass paths into execute and the store-data bypass into memory
 */
module core_fwd_unit (
	input  core_pkg::reg_addr_t exe_rs1,
	input  core_pkg::reg_addr_t exe_rs2,
	input  core_pkg::reg_addr_t mem_rs2,
	input  core_pkg::reg_addr_t mem_rd,
	input  core_pkg::reg_addr_t wb_rd,
	input  logic                mem_we,
	input  logic                wb_we,
	output core_pkg::bp_sel_t   fwd_exe,
	output logic                fwd_mem
);
	// bit positions inside the execute bypass mask
	localparam int M2E_SRC1 = 0;
	localparam int M2E_SRC2 = 1;
	localparam int W2E_SRC1 = 2;
	localparam int W2E_SRC2 = 3;

	// memory result is younger, so it wins over write-back
	always_comb begin
		fwd_exe = '0;
		if (exe_rs1 != '0) begin
			if (mem_we && (mem_rd == exe_rs1)) begin
				fwd_exe[M2E_SRC1] = 1'b1;
			end else if (wb_we && (wb_rd == exe_rs1)) begin
				fwd_exe[W2E_SRC1] = 1'b1;
			end
		end
		if (exe_rs2 != '0) begin
			if (mem_we && (mem_rd == exe_rs2)) begin
				fwd_exe[M2E_SRC2] = 1'b1;
			end else if (wb_we && (wb_rd == exe_rs2)) begin
				fwd_exe[W2E_SRC2] = 1'b1;
			end
		end
	end

	// store data in memory taken from the write-back result
	assign fwd_mem = wb_we && (wb_rd != '0) && (wb_rd == mem_rs2);

endmodule

// ==== core_stall_unit.sv ====
/*
 * core stall unit
 * detects jumps, taken branches, load-use hazards and i-cache stalls
 * and raises the raw enable, kill, bubble and redirect requests
 */
`include "core_defines.svh"

module core_stall_unit (
	input  core_pkg::reg_addr_t   dec_rs1,
	input  core_pkg::reg_addr_t   dec_rs2,
	input  core_pkg::reg_addr_t   exe_rd,
	input  core_pkg::hzrd_cmd_t   exe_cmd,
	input  logic                  brnch_tknn,
	input  logic                  stall_dec,
	output core_pkg::stage_mask_t raw_enb,
	output core_pkg::stage_mask_t raw_kill,
	output logic                  raw_nop,
	output logic                  raw_redirect
);
	import core_pkg::*;

	logic ctrl_flow;
	logic load_use;

	// -----------------------------------------------------------------------
	// hazard detection
	// -----------------------------------------------------------------------

	// jump always leaves, branch only when the alu says taken
	assign ctrl_flow = (exe_cmd == HZRD_JUMP) ||
			((exe_cmd == HZRD_BRNCH) && brnch_tknn);

	// load result not ready for a dependent op sitting in decode
	assign load_use = (exe_cmd == HZRD_LOAD) && (exe_rd != '0) &&
			((exe_rd == dec_rs1) || (exe_rd == dec_rs2));

	// -----------------------------------------------------------------------
	// raw requests
	// -----------------------------------------------------------------------
	always_comb begin
		raw_enb      = '1;
		raw_kill     = '0;
		raw_nop      = 1'b0;
		raw_redirect = 1'b0;

		if (ctrl_flow) begin
			raw_redirect                = 1'b1;
			// wrong-path ops in fetch and decode
			raw_kill[`REG_IF_DEC]  = 1'b1;
			raw_kill[`REG_DEC_EXE] = 1'b1;
		end

		// hold decode and push a bubble into execute
		if (load_use || stall_dec) begin
			raw_enb[`REG_IF_DEC] = 1'b0;
			raw_nop              = 1'b1;
		end
	end

endmodule

// ==== core_hazard_ctrl.sv ====
/*
 * core hazard combiner
 * merges stall and forwarding requests into the final pipeline controls
 */
`include "core_defines.svh"

module core_hazard_ctrl (
	input  logic                  rst_n,
	input  core_pkg::stage_mask_t raw_enb,
	input  core_pkg::stage_mask_t raw_kill,
	input  logic                  raw_nop,
	input  logic                  raw_redirect,
	input  logic                  stall_wb,
	input  core_pkg::bp_sel_t     fwd_exe,
	input  logic                  fwd_mem,
	output core_pkg::stage_mask_t enb_bus,
	output core_pkg::stage_mask_t kill_bus,
	output logic                  nop_gen,
	output logic                  pc_stop,
	output logic                  mux_trn,
	output core_pkg::bp_sel_t     bp_mux_exe,
	output logic                  bp_mux_mem
);
	// -----------------------------------------------------------------------
	// stage control
	// -----------------------------------------------------------------------
	always_comb begin
		enb_bus  = raw_enb;
		kill_bus = raw_kill;
		nop_gen  = raw_nop;
		mux_trn  = raw_redirect;

		if (!rst_n) begin
			// flush everything while in reset
			enb_bus  = '1;
			kill_bus = '1;
			nop_gen  = 1'b0;
			mux_trn  = 1'b0;
		end else if (stall_wb) begin
			// d-cache miss freezes the whole pipe
			enb_bus  = '0;
			kill_bus = '0;
			nop_gen  = 1'b0;
			mux_trn  = 1'b0;
		end else if (raw_redirect) begin
			// redirect wins, decode reloads from the new target
			nop_gen              = 1'b0;
			enb_bus[`REG_IF_DEC] = 1'b1;
		end
	end

	// pc holds whenever some stage register holds
	assign pc_stop = ~&enb_bus;

	// bypass selects
	assign bp_mux_exe = rst_n ? fwd_exe : '0;
	assign bp_mux_mem = rst_n && fwd_mem;

endmodule

// ==== core_hazard_top.sv ====
/*
 * core hazard top
 * stage tracker, forwarding unit, stall unit and hazard combiner
 */
module core_hazard_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  core_pkg::reg_addr_t   dec_rs1,
	input  core_pkg::reg_addr_t   dec_rs2,
	input  core_pkg::reg_addr_t   dec_rd,
	input  logic                  dec_we,
	input  core_pkg::hzrd_cmd_t   dec_cmd,
	input  logic                  brnch_tknn,
	input  logic                  stall_dec,
	input  logic                  stall_wb,
	output core_pkg::stage_mask_t enb_bus,
	output core_pkg::stage_mask_t kill_bus,
	output logic                  nop_gen,
	output logic                  pc_stop,
	output logic                  mux_trn,
	output core_pkg::bp_sel_t     bp_mux_exe,
	output logic                  bp_mux_mem
);
	import core_pkg::*;

	// tracked instruction fields
	reg_addr_t exe_rs1;
	reg_addr_t exe_rs2;
	reg_addr_t exe_rd;
	reg_addr_t mem_rs2;
	reg_addr_t mem_rd;
	reg_addr_t wb_rd;
	logic      exe_we;
	logic      mem_we;
	logic      wb_we;
	hzrd_cmd_t exe_cmd;

	// raw requests into the combiner
	bp_sel_t     fwd_exe;
	logic        fwd_mem;
	stage_mask_t raw_enb;
	stage_mask_t raw_kill;
	logic        raw_nop;
	logic        raw_redirect;

	core_stage_track u_track (
		.clk      (clk),
		.rst_n    (rst_n),
		.dec_rs1  (dec_rs1),
		.dec_rs2  (dec_rs2),
		.dec_rd   (dec_rd),
		.dec_we   (dec_we),
		.dec_cmd  (dec_cmd),
		.enb_bus  (enb_bus),
		.kill_bus (kill_bus),
		.nop_gen  (nop_gen),
		.exe_rs1  (exe_rs1),
		.exe_rs2  (exe_rs2),
		.exe_rd   (exe_rd),
		.mem_rs2  (mem_rs2),
		.mem_rd   (mem_rd),
		.wb_rd    (wb_rd),
		.exe_we   (exe_we),
		.mem_we   (mem_we),
		.wb_we    (wb_we),
		.exe_cmd  (exe_cmd)
	);

	core_fwd_unit u_fwd (
		.exe_rs1 (exe_rs1),
		.exe_rs2 (exe_rs2),
		.mem_rs2 (mem_rs2),
		.mem_rd  (mem_rd),
		.wb_rd   (wb_rd),
		.mem_we  (mem_we),
		.wb_we   (wb_we),
		.fwd_exe (fwd_exe),
		.fwd_mem (fwd_mem)
	);

	core_stall_unit u_stall (
		.dec_rs1      (dec_rs1),
		.dec_rs2      (dec_rs2),
		.exe_rd       (exe_rd),
		.exe_cmd      (exe_cmd),
		.brnch_tknn   (brnch_tknn),
		.stall_dec    (stall_dec),
		.raw_enb      (raw_enb),
		.raw_kill     (raw_kill),
		.raw_nop      (raw_nop),
		.raw_redirect (raw_redirect)
	);

	core_hazard_ctrl u_ctrl (
		.rst_n        (rst_n),
		.raw_enb      (raw_enb),
		.raw_kill     (raw_kill),
		.raw_nop      (raw_nop),
		.raw_redirect (raw_redirect),
		.stall_wb     (stall_wb),
		.fwd_exe      (fwd_exe),
		.fwd_mem      (fwd_mem),
		.enb_bus      (enb_bus),
		.kill_bus     (kill_bus),
		.nop_gen      (nop_gen),
		.pc_stop      (pc_stop),
		.mux_trn      (mux_trn),
		.bp_mux_exe   (bp_mux_exe),
		.bp_mux_mem   (bp_mux_mem)
	);

endmodule

// ==== tb_core_hazard_model.sv ====
/*
 * hazard reference model
 * follows each instruction from decode to write-back and predicts
 * the stage enables, kills, bubble, redirect and bypass selects
 */
`include "core_defines.svh"

module tb_core_hazard_model (
	input  logic                  clk,
	input  logic                  rst_n,
	input  core_pkg::reg_addr_t   dec_rs1,
	input  core_pkg::reg_addr_t   dec_rs2,
	input  core_pkg::reg_addr_t   dec_rd,
	input  logic                  dec_we,
	input  core_pkg::hzrd_cmd_t   dec_cmd,
	input  logic                  brnch_tknn,
	input  logic                  stall_dec,
	input  logic                  stall_wb,
	output core_pkg::stage_mask_t exp_enb,
	output core_pkg::stage_mask_t exp_kill,
	output logic                  exp_nop,
	output logic                  exp_stop,
	output logic                  exp_trn,
	output core_pkg::bp_sel_t     exp_bp_exe,
	output logic                  exp_bp_mem
);
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	// fields held per stage
	reg_addr_t e_rs1, e_rs2, e_rd, m_rs2, m_rd, w_rd;
	logic      e_we, m_we, w_we;
	hzrd_cmd_t e_cmd;
	logic      leave_path;
	logic      hold_dec;
	logic      to_bubble;

	// a source depends on a producer that writes the same non-zero register
	function automatic logic src_hit(reg_addr_t src, reg_addr_t rd, logic we);
		return we && (src != '0) && (src == rd);
	endfunction

	// -----------------------------------------------------------------------
	// expected controls
	// -----------------------------------------------------------------------
	always_comb begin
		leave_path = (e_cmd == HZRD_JUMP) || ((e_cmd == HZRD_BRNCH) && brnch_tknn);
		hold_dec   = stall_dec || ((e_cmd == HZRD_LOAD) &&
				(src_hit(dec_rs1, e_rd, 1'b1) || src_hit(dec_rs2, e_rd, 1'b1)));
		exp_enb  = '1;
		exp_kill = '0;
		exp_nop  = 1'b0;
		exp_trn  = 1'b0;
		if (!rst_n) begin
			exp_kill = '1;
		end else if (stall_wb) begin
			exp_enb = '0;
		end else if (leave_path) begin
			// redirect overrides any bubble request
			exp_trn                = 1'b1;
			exp_kill[`REG_IF_DEC]  = 1'b1;
			exp_kill[`REG_DEC_EXE] = 1'b1;
		end else if (hold_dec) begin
			exp_enb[`REG_IF_DEC] = 1'b0;
			exp_nop              = 1'b1;
		end
		exp_stop  = (exp_enb != '1);
		to_bubble = exp_kill[`REG_DEC_EXE] || exp_nop;

		// memory result first, write-back only when memory misses
		exp_bp_exe = '0;
		if (rst_n) begin
			exp_bp_exe[0] = src_hit(e_rs1, m_rd, m_we);
			exp_bp_exe[1] = src_hit(e_rs2, m_rd, m_we);
			exp_bp_exe[2] = !exp_bp_exe[0] && src_hit(e_rs1, w_rd, w_we);
			exp_bp_exe[3] = !exp_bp_exe[1] && src_hit(e_rs2, w_rd, w_we);
		end
		exp_bp_mem = rst_n && src_hit(m_rs2, w_rd, w_we);
	end

	// stage advance, reset shows up as all enables with all kills
	always @(posedge clk) begin
		if (exp_enb[`REG_DEC_EXE]) begin
			e_rs1 <= to_bubble ? '0 : dec_rs1;
			e_rs2 <= to_bubble ? '0 : dec_rs2;
			e_rd  <= to_bubble ? '0 : dec_rd;
			e_we  <= !to_bubble && dec_we;
			e_cmd <= to_bubble ? HZRD_NONE : dec_cmd;
		end
		if (exp_enb[`REG_EXE_MEM]) begin
			m_rs2 <= exp_kill[`REG_EXE_MEM] ? '0 : e_rs2;
			m_rd  <= exp_kill[`REG_EXE_MEM] ? '0 : e_rd;
			m_we  <= !exp_kill[`REG_EXE_MEM] && e_we;
		end
		if (exp_enb[`REG_MEM_WB]) begin
			w_rd <= exp_kill[`REG_MEM_WB] ? '0 : m_rd;
			w_we <= !exp_kill[`REG_MEM_WB] && m_we;
		end
	end

endmodule

// ==== tb_core_hazard.sv ====
/*
 * core hazard testbench
 * random decode and stall traffic, every output checked each cycle
 */
module tb_core_hazard;
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	localparam int RST_CYCLES = 16;
	localparam int RUN_CYCLES = 2000;
	localparam int MAX_CYCLES = RUN_CYCLES + RST_CYCLES + 100;

	logic        clk = 1'b0;
	logic        rst_n;
	reg_addr_t   dec_rs1, dec_rs2, dec_rd;
	logic        dec_we;
	hzrd_cmd_t   dec_cmd;
	logic        brnch_tknn;
	logic        stall_dec;
	logic        stall_wb;
	stage_mask_t enb_bus, kill_bus, exp_enb, exp_kill;
	bp_sel_t     bp_mux_exe, exp_bp_exe;
	logic        nop_gen, pc_stop, mux_trn, bp_mux_mem;
	logic        exp_nop, exp_stop, exp_trn, exp_bp_mem;
	logic [31:0] lcg_state = 32'h47e200b8;
	int          cycles = 0;

	always #2 clk = ~clk;

	core_hazard_top DUT (.*);
	tb_core_hazard_model model (.*);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// -----------------------------------------------------------------------
	// compare tasks
	// -----------------------------------------------------------------------
	task automatic report_mismatch(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_mask(input string name, input stage_mask_t got,
			input stage_mask_t exp);
		if (got !== exp) begin
			report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
		end
	endtask

	task automatic check_bp(input string name, input bp_sel_t got, input bp_sel_t exp);
		if (got !== exp) begin
			report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
		end
	endtask

	// small register range for frequent hazards, rare cache stalls
	task automatic drive_random();
		logic [31:0] r;
		r          = next_rand();
		dec_rs1    = reg_addr_t'(r[31:29]);
		dec_rs2    = reg_addr_t'(r[28:26]);
		dec_rd     = reg_addr_t'(r[25:23]);
		dec_we     = r[22];
		dec_cmd    = (r[21:18] < 4'd3) ? HZRD_LOAD :
				(r[21:18] < 4'd5) ? HZRD_BRNCH :
				(r[21:18] == 4'd5) ? HZRD_JUMP : HZRD_NONE;
		brnch_tknn = r[17];
		stall_dec  = (r[16:12] == 5'd0);
		stall_wb   = (r[11:7] == 5'd0);
	endtask

	initial begin
		rst_n = 1'b0;
		drive_random();
		for (int i = 0; i < RST_CYCLES + RUN_CYCLES; i++) begin
			@(posedge clk);
			#1;
			rst_n = (i >= RST_CYCLES - 1);
			drive_random();
			#2;
			check_mask("enb_bus", enb_bus, exp_enb);
			check_mask("kill_bus", kill_bus, exp_kill);
			check_bit("nop_gen", nop_gen, exp_nop);
			check_bit("pc_stop", pc_stop, exp_stop);
			check_bit("mux_trn", mux_trn, exp_trn);
			check_bp("bp_mux_exe", bp_mux_exe, exp_bp_exe);
			check_bit("bp_mux_mem", bp_mux_mem, exp_bp_mem);
		end
		$display("Regression passed");
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

endmodule

// ==== core_hazard_top.f ====
+incdir+.
core_pkg.sv
core_stage_track.sv
core_fwd_unit.sv
core_stall_unit.sv
core_hazard_ctrl.sv
core_hazard_top.sv
tb_core_hazard_model.sv
tb_core_hazard.sv

// ==== Bender.yml ====
package:
  name: core_hazard

export_include_dirs:
  - .

sources:
  - core_pkg.sv
  - core_stage_track.sv
  - core_fwd_unit.sv
  - core_stall_unit.sv
  - core_hazard_ctrl.sv
  - core_hazard_top.sv
  - target: test
    files:
      - tb_core_hazard_model.sv
      - tb_core_hazard.sv
